// File: files.f
+incdir+include
rtl/fsab_pkg.sv
rtl/fsab_queue.sv
rtl/fsab_inbound_split.sv
rtl/fsab_mem_engine.sv
rtl/fsab_sim_mem.sv
tb/tb_fsab_sim_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_fsab_sim_mem \
	-o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "FAIL, no pass message in sim.log"; exit 1; }
echo "PASS"

// File: tb/fsab_patterns.txt
// request: mode (1 write, 0 read) did subdid byte_addr len
// a write is followed by its data mask pairs, a read by the data words it returns
// a lone ff in the mode column ends the file
// full-mask writes, read back, and a word that was never written
1 1 0 00000000 1  1111111111111111 ff
1 1 1 00000008 2
	2222222222222222 ff  3333333333333333 ff
0 2 3 00000000 3
	1111111111111111 2222222222222222 3333333333333333
0 2 4 00000100 1  0000000000000000
// partial masks merge with the old bytes
1 3 5 00000008 1  aaaaaaaaaaaaaaaa 0f
1 3 6 00000010 2
	0123456789abcdef 81  fedcba9876543210 3c
0 4 7 00000008 3
	22222222aaaaaaaa 01333333333333ef 0000ba9876540000
// four-beat burst, and a burst that wraps from the top word to word 0
1 5 8 00000200 4
	4444444444444444 ff  5555555555555555 ff
	6666666666666666 ff  7777777777777777 ff
1 6 9 000007f0 3
	8888888888888888 ff  9999999999999999 ff  bbbbbbbbbbbbbbbb f0
0 6 a 000007f8 2
	9999999999999999 bbbbbbbb11111111
0 5 b 00000200 4
	4444444444444444 5555555555555555 6666666666666666 7777777777777777
// short reads back to back, then a read right behind a write
0 7 c 000007f0 1  8888888888888888
0 8 d 00000208 1  5555555555555555
0 9 e 00000018 1  0000ba9876540000
0 a f 00000400 1  0000000000000000
1 b 0 00000400 1  cafef00dcafef00d ff
0 b 1 00000400 2
	cafef00dcafef00d 0000000000000000
0 e 2 00000000 1  bbbbbbbb11111111
ff

// File: tb/tb_fsab_sim_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "fsab_cfg.svh"

module tb_fsab_sim_mem;

	localparam int          PAT_WORDS = 512;
	localparam logic [63:0] PAT_END   = 64'hff;  // mode column value that ends the file.
	localparam int          T_DRV     = 2;       // input skew after the rising edge.

	typedef struct packed {
		logic [`FSAB_DID_W-1:0]  did;
		logic [`FSAB_DID_W-1:0]  subdid;
		logic [`FSAB_DATA_W-1:0] data;
	} exp_beat_t;

	logic                    clk;
	logic                    rst_b;
	logic                    fsabo_valid;
	fsab_pkg::fsab_mode_e    fsabo_mode;
	logic [`FSAB_DID_W-1:0]  fsabo_did;
	logic [`FSAB_DID_W-1:0]  fsabo_subdid;
	logic [`FSAB_ADDR_W-1:0] fsabo_addr;
	logic [`FSAB_LEN_W-1:0]  fsabo_len;
	logic [`FSAB_DATA_W-1:0] fsabo_data;
	logic [`FSAB_MASK_W-1:0] fsabo_mask;
	logic                    fsabo_credit;
	logic                    fsabi_valid;
	logic [`FSAB_DID_W-1:0]  fsabi_did;
	logic [`FSAB_DID_W-1:0]  fsabi_subdid;
	logic [`FSAB_DATA_W-1:0] fsabi_data;

	logic [63:0] pat [PAT_WORDS];
	exp_beat_t   exp_q [$];            // read beats still to come, in order.
	int          credits;              // credits the requester holds.
	int          credit_pulses;
	int          n_req;
	int          n_sent;
	int          errors;
	int          beats_checked;
	int          cycles;
	int          cycle_limit;
	logic [31:0] lfsr;

	fsab_sim_mem u_dut (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr = lfsr_step(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic int count_requests();
		int idx;
		int n;
		bit found;
		idx = 0;
		n = 0;
		found = 1'b0;
		while (!found && idx + 4 < PAT_WORDS) begin
			if (pat[idx] === PAT_END) begin
				found = 1'b1;
			end else begin
				// writes carry two words per beat, reads one.
				idx += 5 + (pat[idx][0] ? 2 : 1) * int'(pat[idx + 4][`FSAB_LEN_W-1:0]);
				n++;
			end
		end
		if (!found) begin
			errors++;
			$display("pattern file is missing or has no end marker");
			n = 0;
		end
		return n;
	endfunction

	task automatic check_data(input string name, input logic [`FSAB_DATA_W-1:0] got,
			input logic [`FSAB_DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_id(input string name, input logic [`FSAB_DID_W-1:0] got,
			input logic [`FSAB_DID_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic idle_cycle();
		fsabo_valid = 1'b0;
		@(posedge clk);
		#T_DRV;
	endtask

	// drives one request from the pattern array and queues its read beats.
	task automatic send_request(inout int idx);
		logic                   is_write;
		logic [`FSAB_LEN_W-1:0] len;
		exp_beat_t              e;
		is_write     = pat[idx][0];
		len          = pat[idx + 4][`FSAB_LEN_W-1:0];
		fsabo_mode   = is_write ? fsab_pkg::FSAB_WRITE : fsab_pkg::FSAB_READ;
		fsabo_did    = pat[idx + 1][`FSAB_DID_W-1:0];
		fsabo_subdid = pat[idx + 2][`FSAB_DID_W-1:0];
		fsabo_addr   = pat[idx + 3][`FSAB_ADDR_W-1:0];
		fsabo_len    = len;
		idx += 5;
		credits--;
		n_sent++;
		if (is_write) begin
			for (int k = 0; k < int'(len); k++) begin
				fsabo_valid = 1'b1;
				fsabo_data  = pat[idx];
				fsabo_mask  = pat[idx + 1][`FSAB_MASK_W-1:0];
				idx += 2;
				@(posedge clk);
				#T_DRV;
			end
		end else begin
			for (int k = 0; k < int'(len); k++) begin
				e.did    = fsabo_did;
				e.subdid = fsabo_subdid;
				e.data   = pat[idx];
				exp_q.push_back(e);
				idx++;
			end
			fsabo_valid = 1'b1;
			fsabo_data  = '0;   // dummy beat of a read.
			fsabo_mask  = '0;
			@(posedge clk);
			#T_DRV;
		end
	endtask

	// ----------------------------------------
	// monitor and timeout
	// ----------------------------------------
	always @(negedge clk) begin
		exp_beat_t e;
		if (rst_b) begin
			if (fsabo_credit) begin
				credit_pulses++;
				credits++;
				if (credits > `FSAB_CREDITS) begin
					errors++;
					$display("credit returned with no request outstanding");
				end
			end
			if (fsabi_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("read beat returned with no read outstanding");
				end else begin
					e = exp_q.pop_front();
					check_id("fsabi_did", fsabi_did, e.did);
					check_id("fsabi_subdid", fsabi_subdid, e.subdid);
					check_data("fsabi_data", fsabi_data, e.data);
					beats_checked++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped returning credits or beats",
				cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int idx;
		int gap;
		rst_b         = 1'b0;
		fsabo_valid   = 1'b0;
		fsabo_mode    = fsab_pkg::FSAB_READ;
		fsabo_did     = '0;
		fsabo_subdid  = '0;
		fsabo_addr    = '0;
		fsabo_len     = '0;
		fsabo_data    = '0;
		fsabo_mask    = '0;
		credits       = `FSAB_CREDITS;
		credit_pulses = 0;
		n_sent        = 0;
		errors        = 0;
		beats_checked = 0;
		cycles        = 0;
		lfsr          = 32'hbed46063;
		$readmemh("tb/fsab_patterns.txt", pat);
		n_req       = count_requests();
		cycle_limit = 30 * n_req + 200;
		repeat (2) @(posedge clk);
		#T_DRV;
		rst_b = 1'b1;

		// the bus stays quiet until the first request.
		repeat (4) begin
			@(negedge clk);
			if (fsabo_credit || fsabi_valid) begin
				errors++;
				$display("credit or read beat seen before any request was sent");
			end
		end
		@(posedge clk);
		#T_DRV;

		idx = 0;
		while (n_sent < n_req) begin
			draw_gap(gap);
			repeat (gap) idle_cycle();
			while (credits == 0)
				idle_cycle();
			send_request(idx);
		end
		fsabo_valid = 1'b0;

		while (credit_pulses < n_sent || exp_q.size() != 0)
			@(posedge clk);
		repeat (5) @(posedge clk);  // catch stray pulses.

		if (credit_pulses != n_sent) begin
			errors++;
			$display("%0d credit pulses seen for %0d requests", credit_pulses, n_sent);
		end
		if (credits != `FSAB_CREDITS) begin
			errors++;
			$display("requester ends holding %0d credits", credits);
		end
		$display("errors: %0d, requests: %0d, read beats checked: %0d",
			errors, n_sent, beats_checked);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/fsab_sim_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "fsab_cfg.svh"

module fsab_sim_mem (
	input  logic                     clk,
	input  logic                     rst_b,

	input  logic                     fsabo_valid,
	input  fsab_pkg::fsab_mode_e     fsabo_mode,
	input  logic [`FSAB_DID_W-1:0]   fsabo_did,
	input  logic [`FSAB_DID_W-1:0]   fsabo_subdid,
	input  logic [`FSAB_ADDR_W-1:0]  fsabo_addr,
	input  logic [`FSAB_LEN_W-1:0]   fsabo_len,
	input  logic [`FSAB_DATA_W-1:0]  fsabo_data,
	input  logic [`FSAB_MASK_W-1:0]  fsabo_mask,
	output logic                     fsabo_credit,

	output logic                     fsabi_valid,
	output logic [`FSAB_DID_W-1:0]   fsabi_did,
	output logic [`FSAB_DID_W-1:0]   fsabi_subdid,
	output logic [`FSAB_DATA_W-1:0]  fsabi_data
);

	logic                 req_push;
	fsab_pkg::fsab_req_t  req_in;
	logic                 req_pop;
	fsab_pkg::fsab_req_t  req_head;
	logic                 req_ready;

	logic                 beat_push;
	fsab_pkg::fsab_beat_t beat_in;
	logic                 beat_pop;
	fsab_pkg::fsab_beat_t beat_head;
	logic                 beat_ready;

	// ----------------------------------------
	// inbound side
	// ----------------------------------------
	fsab_inbound_split u_split (
		.clk       (clk),
		.rst_b     (rst_b),
		.valid     (fsabo_valid),
		.mode      (fsabo_mode),
		.did       (fsabo_did),
		.subdid    (fsabo_subdid),
		.addr      (fsabo_addr),
		.len       (fsabo_len),
		.data      (fsabo_data),
		.mask      (fsabo_mask),
		.req_push  (req_push),
		.req       (req_in),
		.beat_push (beat_push),
		.beat      (beat_in)
	);

	// one header slot per credit.
	fsab_queue #(
		.payload_t (fsab_pkg::fsab_req_t),
		.DEPTH     (`FSAB_CREDITS)
	) u_req_q (
		.clk       (clk),
		.rst_b     (rst_b),
		.push      (req_push),
		.wdata     (req_in),
		.pop       (req_pop),
		.rdata     (req_head),
		.not_empty (req_ready)
	);

	// room for a full burst behind every credit.
	fsab_queue #(
		.payload_t (fsab_pkg::fsab_beat_t),
		.DEPTH     (`FSAB_CREDITS * `FSAB_LEN_MAX)
	) u_beat_q (
		.clk       (clk),
		.rst_b     (rst_b),
		.push      (beat_push),
		.wdata     (beat_in),
		.pop       (beat_pop),
		.rdata     (beat_head),
		.not_empty (beat_ready)
	);

	// ----------------------------------------
	// service and return path
	// ----------------------------------------
	fsab_mem_engine u_engine (
		.clk        (clk),
		.rst_b      (rst_b),
		.req_head   (req_head),
		.req_ready  (req_ready),
		.req_pop    (req_pop),
		.beat_head  (beat_head),
		.beat_ready (beat_ready),
		.beat_pop   (beat_pop),
		.credit     (fsabo_credit),
		.rd_valid   (fsabi_valid),
		.rd_did     (fsabi_did),
		.rd_subdid  (fsabi_subdid),
		.rd_data    (fsabi_data)
	);

endmodule

`default_nettype wire

// File: rtl/fsab_mem_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "fsab_cfg.svh"

module fsab_mem_engine (
	input  logic                     clk,
	input  logic                     rst_b,
	input  fsab_pkg::fsab_req_t      req_head,
	input  logic                     req_ready,
	output logic                     req_pop,
	input  fsab_pkg::fsab_beat_t     beat_head,
	input  logic                     beat_ready,
	output logic                     beat_pop,
	output logic                     credit,
	output logic                     rd_valid,
	output logic [`FSAB_DID_W-1:0]   rd_did,
	output logic [`FSAB_DID_W-1:0]   rd_subdid,
	output logic [`FSAB_DATA_W-1:0]  rd_data
);

	localparam int WORD_W = $clog2(`FSAB_MEM_WORDS);
	localparam int OFS_W  = $clog2(`FSAB_MASK_W);

	logic [`FSAB_DATA_W-1:0] mem [`FSAB_MEM_WORDS];

	logic                    active;     // a request is in service.
	logic                    hdr_cyc;    // req_head holds a freshly popped header.
	logic                    beat_cyc;   // beat_head holds a freshly popped beat.
	logic                    write_r;
	logic [`FSAB_DID_W-1:0]  did_r;
	logic [`FSAB_DID_W-1:0]  subdid_r;
	logic [WORD_W-1:0]       addr_r;     // word for the next write or read.
	logic [`FSAB_LEN_W-1:0]  rem_r;      // beats still to write or return.
	logic [`FSAB_LEN_W-1:0]  pops_r;     // write beats still to pop.

	logic                    cur_write;
	logic [WORD_W-1:0]       cur_addr;
	logic [`FSAB_LEN_W-1:0]  cur_rem;
	logic [`FSAB_LEN_W-1:0]  cur_pops;
	logic                    wr_en;
	logic                    consume;
	logic                    done;
	logic [`FSAB_DATA_W-1:0] merged;

	initial begin
		for (int i = 0; i < `FSAB_MEM_WORDS; i++)
			mem[i] = '0;
	end

	// ----------------------------------------
	// current request view
	// ----------------------------------------
	// In the header cycle the request registers are not loaded yet, so the
	// fields come straight from the queue head.
	assign cur_write = hdr_cyc ? (req_head.mode == fsab_pkg::FSAB_WRITE) : write_r;
	assign cur_addr  = hdr_cyc ? req_head.addr[OFS_W +: WORD_W] : addr_r;
	assign cur_rem   = hdr_cyc ? req_head.len : rem_r;
	assign cur_pops  = hdr_cyc ? req_head.len - 1'b1 : pops_r;

	// ----------------------------------------
	// pops
	// ----------------------------------------
	assign req_pop  = !active && req_ready;  // a header only while idle.
	assign beat_pop = req_pop ||                   // the header's own beat.
		(active && cur_write && (cur_pops != '0) && beat_ready);

	// ----------------------------------------
	// beat consumption
	// ----------------------------------------
	assign wr_en    = active && cur_write && beat_cyc;
	assign rd_valid = active && !hdr_cyc && !write_r && (rem_r != '0);
	assign consume  = wr_en || rd_valid;
	assign done     = consume && (cur_rem == 1);

	assign rd_did    = did_r;
	assign rd_subdid = subdid_r;
	assign rd_data   = mem[addr_r];

	// byte-wise merge of the beat into the addressed word.
	always_comb begin
		merged = mem[cur_addr];
		for (int b = 0; b < `FSAB_MASK_W; b++) begin
			if (beat_head.mask[b])
				merged[8*b +: 8] = beat_head.data[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[cur_addr] <= merged;
	end

	// ----------------------------------------
	// control state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			active   <= 1'b0;
			hdr_cyc  <= 1'b0;
			beat_cyc <= 1'b0;
			credit   <= 1'b0;
			write_r  <= 1'b0;
			rem_r    <= '0;
			pops_r   <= '0;
		end else begin
			hdr_cyc  <= req_pop;
			beat_cyc <= beat_pop;
			credit   <= done;  // one pulse as the engine goes idle.
			if (req_pop)
				active <= 1'b1;
			else if (done)
				active <= 1'b0;
			if (hdr_cyc)
				write_r <= cur_write;
			if (hdr_cyc || consume)
				rem_r <= consume ? cur_rem - 1'b1 : cur_rem;
			if (hdr_cyc || (beat_pop && active))
				pops_r <= (beat_pop && active) ? cur_pops - 1'b1 : cur_pops;
		end
	end

	// request fields captured from the header.
	always_ff @(posedge clk) begin
		if (hdr_cyc) begin
			did_r    <= req_head.did;
			subdid_r <= req_head.subdid;
		end
		if (hdr_cyc || consume)
			addr_r <= consume ? cur_addr + 1'b1 : cur_addr;  // wraps at the top word.
	end

	// a header in its queue implies its first beat is already in the other.
	a_beat_ready: assert property (@(posedge clk) disable iff (!rst_b)
		req_pop |-> beat_ready)
		else $error("fsab_mem_engine: header popped with its first beat missing");

endmodule

`default_nettype wire

// File: rtl/fsab_inbound_split.sv
`timescale 1ns/1ns
`default_nettype none

`include "fsab_cfg.svh"

module fsab_inbound_split (
	input  logic                     clk,
	input  logic                     rst_b,
	input  logic                     valid,
	input  fsab_pkg::fsab_mode_e     mode,
	input  logic [`FSAB_DID_W-1:0]   did,
	input  logic [`FSAB_DID_W-1:0]   subdid,
	input  logic [`FSAB_ADDR_W-1:0]  addr,
	input  logic [`FSAB_LEN_W-1:0]   len,
	input  logic [`FSAB_DATA_W-1:0]  data,
	input  logic [`FSAB_MASK_W-1:0]  mask,
	output logic                     req_push,
	output fsab_pkg::fsab_req_t      req,
	output logic                     beat_push,
	output fsab_pkg::fsab_beat_t     beat
);

	logic [`FSAB_LEN_W-1:0] rem;     // write beats still to come after this cycle.
	logic                   header;

	// a valid cycle with no write beats outstanding opens a new request.
	assign header = valid && (rem == '0);

	// ----------------------------------------
	// burst tracking
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			rem <= '0;
		end else if (header) begin
			if (mode == fsab_pkg::FSAB_WRITE)
				rem <= len - 1'b1;  // the header already carried beat 0.
		end else if (valid) begin
			rem <= rem - 1'b1;
		end
	end

	// ----------------------------------------
	// queue feeds
	// ----------------------------------------
	assign req_push  = header;
	assign req       = '{mode: mode, did: did, subdid: subdid, addr: addr, len: len};
	assign beat_push = valid;  // reads push a dummy beat as well.
	assign beat      = '{data: data, mask: mask};

	a_len_legal: assert property (@(posedge clk) disable iff (!rst_b)
		header |-> (len != '0) && (len <= `FSAB_LEN_MAX))
		else $error("fsab_inbound_split: illegal burst length %0d", len);

endmodule

`default_nettype wire

// File: rtl/fsab_queue.sv
`timescale 1ns/1ns
`default_nettype none

// Synchronous FIFO that carries any packed payload. DEPTH must be a
// power of two, the pointers carry one extra bit to tell full from empty.
module fsab_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_b,
	input  logic     push,
	input  payload_t wdata,
	input  logic     pop,
	output payload_t rdata,
	output logic     not_empty
);

	localparam int AW = $clog2(DEPTH);

	payload_t        store [DEPTH];
	logic [AW:0]     wptr;
	logic [AW:0]     rptr;
	logic            full;

	// ----------------------------------------
	// status
	// ----------------------------------------
	assign not_empty = (wptr != rptr);
	assign full      = (wptr[AW-1:0] == rptr[AW-1:0]) && (wptr[AW] != rptr[AW]);

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push)
				wptr <= wptr + 1'b1;  // wraps through the extra bit.
			if (pop)
				rptr <= rptr + 1'b1;
		end
	end

	// ----------------------------------------
	// storage and registered head
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (push)
			store[wptr[AW-1:0]] <= wdata;
		if (pop)
			rdata <= store[rptr[AW-1:0]];  // head is valid the cycle after the pop.
	end

	// the sender must respect credits, so the queue never sees an overflow.
	a_push_full: assert property (@(posedge clk) disable iff (!rst_b)
		!(push && full))
		else $error("fsab_queue: push while full");

	// the consumer only pops what it has seen as present.
	a_pop_empty: assert property (@(posedge clk) disable iff (!rst_b)
		!(pop && !not_empty))
		else $error("fsab_queue: pop while empty");

endmodule

`default_nettype wire

// File: rtl/fsab_pkg.sv
`default_nettype none

`include "fsab_cfg.svh"

package fsab_pkg;

	// ----------------------------------------
	// request kind
	// ----------------------------------------
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	// ----------------------------------------
	// request header, one per request
	// ----------------------------------------
	typedef struct packed {
		fsab_mode_e              mode;    // read or write.
		logic [`FSAB_DID_W-1:0]  did;     // requesting device.
		logic [`FSAB_DID_W-1:0]  subdid;  // tag inside the device.
		logic [`FSAB_ADDR_W-1:0] addr;    // byte address of beat 0.
		logic [`FSAB_LEN_W-1:0]  len;     // number of beats.
	} fsab_req_t;

	// ----------------------------------------
	// data beat, one per valid cycle
	// ----------------------------------------
	typedef struct packed {
		logic [`FSAB_DATA_W-1:0] data;
		logic [`FSAB_MASK_W-1:0] mask;    // byte enables, bit k covers data[8k+7:8k].
	} fsab_beat_t;

endpackage

`default_nettype wire

// File: include/fsab_cfg.svh
`ifndef FSAB_CFG_SVH
`define FSAB_CFG_SVH

// ----------------------------------------
// bus geometry
// ----------------------------------------
`define FSAB_DATA_W    64   // one beat is a 64-bit word.
`define FSAB_MASK_W    8    // one enable bit per data byte.
`define FSAB_ADDR_W    32   // byte address.
`define FSAB_DID_W     4    // width of did and of subdid.
`define FSAB_LEN_W     3    // burst length field.

// ----------------------------------------
// flow control and storage
// ----------------------------------------
`define FSAB_LEN_MAX   4    // longest legal burst in beats.
`define FSAB_CREDITS   4    // credits held by the requester after reset.

// storage depth in words. Must be a power of two so word addresses wrap.
`define FSAB_MEM_WORDS 256

`endif
